// File: logic/avr_params.svh
`ifndef AVR_PARAMS_SVH
`define AVR_PARAMS_SVH

// General purpose registers r0 to r31
`define AVR_NUM_REGS 32

// Word address of the first instruction
`define AVR_RESET_PC 16'd0

// OUT port numbers are offsets from here
`define AVR_IO_BASE 16'h0200

// Status register bit positions
`define AVR_SREG_C 0
`define AVR_SREG_Z 1
`define AVR_SREG_N 2
`define AVR_SREG_V 3
`define AVR_SREG_S 4
// Half carry, out of bit 3
`define AVR_SREG_H 5

`endif

// File: logic/avr_pkg.sv
package avr_pkg;

	// Instruction word, program address or I/O address
	typedef logic [15:0] word_t;

	// Register value, ALU operand or result
	typedef logic [7:0] byte_t;

	// Register file index, r0 to r31
	typedef logic [4:0] reg_idx_t;

	// Status register, packed as I T H S V N Z C
	typedef logic [7:0] sreg_t;

	// ALU operation selected by the decoder
	typedef enum logic [3:0] {
		ALU_NONE,
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_SBC,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		// Second operand straight to the result
		ALU_PASS
	} alu_op_e;

	// How a result updates the status flags
	typedef enum logic [1:0] {
		FLAGS_NONE,
		FLAGS_ARITH,
		FLAGS_LOGIC,
		// Subtract flags, new Z ANDed with old Z
		FLAGS_CHAIN
	} flag_mode_e;

endpackage

// File: logic/fetch_stage.sv
`include "avr_params.svh"

module fetch_stage (
	input  logic          clk,
	input  logic          reset,
	input  avr_pkg::word_t cdata,
	input  logic          redirect,
	input  avr_pkg::word_t redirect_target,
	output avr_pkg::word_t pc,
	output avr_pkg::word_t instr,
	output avr_pkg::word_t instr_pc,
	output logic          instr_valid
);

	// Program counter and valid flag
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `AVR_RESET_PC;
			instr_valid <= 1'b0;
		end else if (redirect) begin
			// Wrong-path word is dropped, one bubble
			pc <= redirect_target;
			instr_valid <= 1'b0;
		end else begin
			pc <= pc + 16'd1;
			instr_valid <= 1'b1;
		end
	end

	// Instruction register
	// Memory answers combinationally for the current pc
	always_ff @(posedge clk) begin
		instr <= cdata;
		instr_pc <= pc;
	end

endmodule

// File: logic/instr_decoder.sv
module instr_decoder (
	input  avr_pkg::word_t     instr,
	output avr_pkg::alu_op_e   alu_op,
	output avr_pkg::flag_mode_e flag_mode,
	output avr_pkg::reg_idx_t  rd_idx,
	output avr_pkg::reg_idx_t  rr_idx,
	output avr_pkg::byte_t     imm,
	output logic              use_imm,
	output logic              write_rd,
	output logic              is_out,
	output logic [5:0]        io_port,
	output logic              is_rjmp,
	output logic              is_branch,
	output logic [2:0]        branch_bit,
	output logic              branch_if_set,
	output avr_pkg::word_t     offset
);
	import avr_pkg::*;

	// Fixed field positions
	assign rr_idx = {instr[9], instr[3:0]};
	assign imm = {instr[11:8], instr[3:0]};
	assign io_port = {instr[10:9], instr[3:0]};
	assign branch_bit = instr[2:0];
	// BRBS has bit 10 clear, BRBC has it set
	assign branch_if_set = ~instr[10];

	// 7-bit branch offset or 12-bit jump offset, sign extended
	assign offset = is_branch ? {{9{instr[9]}}, instr[9:3]} : {{4{instr[11]}}, instr[11:0]};

	always_comb begin
		alu_op = ALU_NONE;
		flag_mode = FLAGS_NONE;
		use_imm = 1'b0;
		write_rd = 1'b0;
		is_out = 1'b0;
		is_rjmp = 1'b0;
		is_branch = 1'b0;
		casez (instr)
		// Two register operations
		// ADD and ADC with Rd equal to Rr give LSL and ROL
		16'b0000_01??_????_????: {alu_op, flag_mode} = {ALU_SBC, FLAGS_CHAIN};
		16'b0000_10??_????_????: {alu_op, flag_mode, write_rd} = {ALU_SBC, FLAGS_CHAIN, 1'b1};
		16'b0000_11??_????_????: {alu_op, flag_mode, write_rd} = {ALU_ADD, FLAGS_ARITH, 1'b1};
		16'b0001_01??_????_????: {alu_op, flag_mode} = {ALU_SUB, FLAGS_ARITH};
		16'b0001_10??_????_????: {alu_op, flag_mode, write_rd} = {ALU_SUB, FLAGS_ARITH, 1'b1};
		16'b0001_11??_????_????: {alu_op, flag_mode, write_rd} = {ALU_ADC, FLAGS_ARITH, 1'b1};
		16'b0010_00??_????_????: {alu_op, flag_mode, write_rd} = {ALU_AND, FLAGS_LOGIC, 1'b1};
		16'b0010_01??_????_????: {alu_op, flag_mode, write_rd} = {ALU_EOR, FLAGS_LOGIC, 1'b1};
		16'b0010_10??_????_????: {alu_op, flag_mode, write_rd} = {ALU_OR, FLAGS_LOGIC, 1'b1};
		16'b0010_11??_????_????: {alu_op, write_rd} = {ALU_PASS, 1'b1};
		// Immediate operations on r16 to r31
		16'b0011_????_????_????: {alu_op, flag_mode, use_imm} = {ALU_SUB, FLAGS_ARITH, 1'b1};
		16'b0100_????_????_????: begin
			{alu_op, flag_mode} = {ALU_SBC, FLAGS_CHAIN};
			{use_imm, write_rd} = 2'b11;
		end
		16'b0101_????_????_????: begin
			{alu_op, flag_mode} = {ALU_SUB, FLAGS_ARITH};
			{use_imm, write_rd} = 2'b11;
		end
		16'b0110_????_????_????: begin
			{alu_op, flag_mode} = {ALU_OR, FLAGS_LOGIC};
			{use_imm, write_rd} = 2'b11;
		end
		16'b0111_????_????_????: begin
			{alu_op, flag_mode} = {ALU_AND, FLAGS_LOGIC};
			{use_imm, write_rd} = 2'b11;
		end
		16'b1110_????_????_????: {alu_op, use_imm, write_rd} = {ALU_PASS, 2'b11};
		// OUT, source register sits in the Rd field
		16'b1011_1???_????_????: is_out = 1'b1;
		16'b1100_????_????_????: is_rjmp = 1'b1;
		// BRBS and BRBC
		16'b1111_0???_????_????: is_branch = 1'b1;
		// Everything else runs as a no-op
		default: ;
		endcase
	end

	// Immediate forms only reach the upper sixteen registers
	assign rd_idx = use_imm ? {1'b1, instr[7:4]} : instr[8:4];

endmodule

// File: logic/alu.sv
`include "avr_params.svh"

module alu (
	input  avr_pkg::alu_op_e    alu_op,
	input  avr_pkg::flag_mode_e flag_mode,
	input  avr_pkg::byte_t      a,
	input  avr_pkg::byte_t      b,
	input  avr_pkg::sreg_t      sreg,
	output avr_pkg::byte_t      result,
	output avr_pkg::sreg_t      next_sreg
);
	import avr_pkg::*;

	logic carry_in;
	logic is_sub;
	logic zero;
	logic h_add;
	logic h_sub;
	logic v_add;
	logic v_sub;
	logic c_add;
	logic c_sub;
	logic v_flag;

	// Only ADC and SBC take the old carry
	assign carry_in = ((alu_op == ALU_ADC) || (alu_op == ALU_SBC)) && sreg[`AVR_SREG_C];
	assign is_sub = (alu_op == ALU_SUB) || (alu_op == ALU_SBC);

	always_comb begin
		case (alu_op)
		ALU_ADD, ALU_ADC: result = a + b + {7'b0, carry_in};
		ALU_SUB, ALU_SBC: result = a - b - {7'b0, carry_in};
		ALU_AND: result = a & b;
		ALU_OR: result = a | b;
		ALU_EOR: result = a ^ b;
		ALU_PASS: result = b;
		default: result = 8'h00;
		endcase
	end

	assign zero = (result == 8'h00);

	// Carry out of bit 3 and bit 7 for an add
	assign h_add = (a[3] & b[3]) | (b[3] & ~result[3]) | (~result[3] & a[3]);
	assign c_add = (a[7] & b[7]) | (b[7] & ~result[7]) | (~result[7] & a[7]);
	// Two's complement overflow for an add
	assign v_add = (a[7] & b[7] & ~result[7]) | (~a[7] & ~b[7] & result[7]);

	// Borrow into bit 3 and bit 7 for a subtract
	assign h_sub = (~a[3] & b[3]) | (b[3] & result[3]) | (result[3] & ~a[3]);
	assign c_sub = (~a[7] & b[7]) | (b[7] & result[7]) | (result[7] & ~a[7]);
	assign v_sub = (a[7] & ~b[7] & ~result[7]) | (~a[7] & b[7] & result[7]);

	assign v_flag = is_sub ? v_sub : v_add;

	always_comb begin
		// I and T always pass through
		next_sreg = sreg;
		case (flag_mode)
		FLAGS_ARITH, FLAGS_CHAIN: begin
			next_sreg[`AVR_SREG_H] = is_sub ? h_sub : h_add;
			next_sreg[`AVR_SREG_V] = v_flag;
			next_sreg[`AVR_SREG_N] = result[7];
			next_sreg[`AVR_SREG_S] = result[7] ^ v_flag;
			next_sreg[`AVR_SREG_C] = is_sub ? c_sub : c_add;
			// Multi-byte compare keeps Z only if every byte was zero
			if (flag_mode == FLAGS_CHAIN) begin
				next_sreg[`AVR_SREG_Z] = zero & sreg[`AVR_SREG_Z];
			end else begin
				next_sreg[`AVR_SREG_Z] = zero;
			end
		end
		FLAGS_LOGIC: begin
			// H and C left alone
			next_sreg[`AVR_SREG_V] = 1'b0;
			next_sreg[`AVR_SREG_N] = result[7];
			next_sreg[`AVR_SREG_S] = result[7];
			next_sreg[`AVR_SREG_Z] = zero;
		end
		default: ;
		endcase
	end

endmodule

// File: logic/register_file.sv
`include "avr_params.svh"

module register_file (
	input  logic             clk,
	input  logic             reset,
	input  avr_pkg::reg_idx_t rd_idx,
	input  avr_pkg::reg_idx_t rr_idx,
	output avr_pkg::byte_t    rd_value,
	output avr_pkg::byte_t    rr_value,
	input  logic             write_en,
	input  avr_pkg::byte_t    write_value
);
	import avr_pkg::*;

	// Flops, not a block RAM
	byte_t regs [`AVR_NUM_REGS];

	// Both reads are combinational
	assign rd_value = regs[rd_idx];
	assign rr_value = regs[rr_idx];

	// Results always land in the destination register
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `AVR_NUM_REGS; i++) begin
				regs[i] <= 8'h00;
			end
		end else if (write_en) begin
			regs[rd_idx] <= write_value;
		end
	end

endmodule

// File: logic/execute_stage.sv
`include "avr_params.svh"

module execute_stage (
	input  logic          clk,
	input  logic          reset,
	input  avr_pkg::word_t instr,
	input  avr_pkg::word_t instr_pc,
	input  logic          instr_valid,
	output logic          redirect,
	output avr_pkg::word_t redirect_target,
	output avr_pkg::word_t data_addr,
	output logic          data_wen,
	output avr_pkg::byte_t data_write
);
	import avr_pkg::*;

	alu_op_e alu_op;
	flag_mode_e flag_mode;
	reg_idx_t rd_idx;
	reg_idx_t rr_idx;
	byte_t imm;
	logic use_imm;
	logic write_rd;
	logic is_out;
	logic [5:0] io_port;
	logic is_rjmp;
	logic is_branch;
	logic [2:0] branch_bit;
	logic branch_if_set;
	word_t offset;
	byte_t rd_value;
	byte_t rr_value;
	byte_t operand_b;
	byte_t alu_result;
	sreg_t sreg;
	sreg_t next_sreg;
	logic branch_taken;

	instr_decoder i_decoder (
		.instr(instr),
		.alu_op(alu_op),
		.flag_mode(flag_mode),
		.rd_idx(rd_idx),
		.rr_idx(rr_idx),
		.imm(imm),
		.use_imm(use_imm),
		.write_rd(write_rd),
		.is_out(is_out),
		.io_port(io_port),
		.is_rjmp(is_rjmp),
		.is_branch(is_branch),
		.branch_bit(branch_bit),
		.branch_if_set(branch_if_set),
		.offset(offset)
	);

	// Bubbles write nothing
	register_file i_regs (
		.clk(clk),
		.reset(reset),
		.rd_idx(rd_idx),
		.rr_idx(rr_idx),
		.rd_value(rd_value),
		.rr_value(rr_value),
		.write_en(instr_valid && write_rd),
		.write_value(alu_result)
	);

	assign operand_b = use_imm ? imm : rr_value;

	alu i_alu (
		.alu_op(alu_op),
		.flag_mode(flag_mode),
		.a(rd_value),
		.b(operand_b),
		.sreg(sreg),
		.result(alu_result),
		.next_sreg(next_sreg)
	);

	// Status register
	// Non-ALU instructions hand back the old value
	always_ff @(posedge clk) begin
		if (reset) begin
			sreg <= 8'h00;
		end else if (instr_valid) begin
			sreg <= next_sreg;
		end
	end

	// Taken when the tested bit matches the BRBS/BRBC sense
	assign branch_taken = is_branch && (sreg[branch_bit] != !branch_if_set);
	assign redirect = instr_valid && (is_rjmp || branch_taken);
	// Offsets count from the following word
	assign redirect_target = instr_pc + 16'd1 + offset;

	// OUT strobe, one cycle after the instruction
	always_ff @(posedge clk) begin
		if (reset) begin
			data_wen <= 1'b0;
		end else begin
			data_wen <= instr_valid && is_out;
		end
	end

	// Address and data held until the next OUT
	always_ff @(posedge clk) begin
		if (instr_valid && is_out) begin
			data_addr <= `AVR_IO_BASE + {10'b0, io_port};
			data_write <= rd_value;
		end
	end

endmodule

// File: logic/avr_core.sv
module avr_core (
	input  logic          clk,
	input  logic          reset,
	output avr_pkg::word_t pc,
	input  avr_pkg::word_t cdata,
	output avr_pkg::word_t data_addr,
	output logic          data_wen,
	output avr_pkg::byte_t data_write
);
	import avr_pkg::*;

	// Fetch to execute
	word_t instr;
	word_t instr_pc;
	logic instr_valid;

	// Execute back to fetch on a taken jump
	logic redirect;
	word_t redirect_target;

	// Program memory side
	fetch_stage i_fetch (
		.clk(clk),
		.reset(reset),
		.cdata(cdata),
		.redirect(redirect),
		.redirect_target(redirect_target),
		.pc(pc),
		.instr(instr),
		.instr_pc(instr_pc),
		.instr_valid(instr_valid)
	);

	// I/O write bus side
	execute_stage i_execute (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instr_pc(instr_pc),
		.instr_valid(instr_valid),
		.redirect(redirect),
		.redirect_target(redirect_target),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_write(data_write)
	);

endmodule

// File: verification/avr_core_tb.sv
`include "avr_params.svh"

module avr_core_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import avr_pkg::*;

	// Two-register opcodes, bits 15 to 10
	localparam logic [5:0] op_cpc = 6'b000001;
	localparam logic [5:0] op_add = 6'b000011;
	localparam logic [5:0] op_cp = 6'b000101;
	localparam logic [5:0] op_adc = 6'b000111;
	localparam logic [5:0] op_and = 6'b001000;
	localparam logic [5:0] op_eor = 6'b001001;
	localparam logic [5:0] op_or = 6'b001010;
	localparam logic [5:0] op_mov = 6'b001011;
	// Immediate opcodes, bits 15 to 12
	localparam logic [3:0] op_cpi = 4'b0011;
	localparam logic [3:0] op_sbci = 4'b0100;
	localparam logic [3:0] op_subi = 4'b0101;
	localparam logic [3:0] op_ori = 4'b0110;
	localparam logic [3:0] op_andi = 4'b0111;
	localparam logic [3:0] op_ldi = 4'b1110;

	localparam int write_timeout = 100;
	localparam int quiet_cycles = 40;
	localparam word_t nop_word = 16'h0000;

	logic clk;
	logic reset;
	word_t pc;
	word_t cdata;
	word_t data_addr;
	logic data_wen;
	byte_t data_write;

	// Program image, only the first prog_len words are code
	word_t program_words [128];
	word_t prog_len;

	// Expected OUT writes, in order
	string exp_names [$];
	word_t exp_addrs [$];
	byte_t exp_data [$];

	avr_core i_dut (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.cdata(cdata),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_write(data_write)
	);

	// Program memory answers in the same cycle, NOP past the end
	assign cdata = (pc < prog_len) ? program_words[pc[6:0]] : nop_word;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Instruction encoders
	function automatic word_t two_reg(input logic [5:0] opcode, input int rd, input int rr);
		return {opcode, rr[4], rd[4:0], rr[3:0]};
	endfunction

	// Destination must be r16 to r31
	function automatic word_t reg_imm(input logic [3:0] opcode, input int rd, input byte_t k);
		return {opcode, k[7:4], rd[3:0], k[3:0]};
	endfunction

	function automatic word_t out_port(input int port, input int rr);
		return {5'b10111, port[5:4], rr[4:0], port[3:0]};
	endfunction

	// Offset counts from the word after the jump
	function automatic word_t rel_jump(input int offset);
		return {4'b1100, offset[11:0]};
	endfunction

	// BRBS when if_set is high, BRBC otherwise
	function automatic word_t cond_branch(input logic if_set, input int sreg_bit, input int offset);
		return {5'b11110, ~if_set, offset[6:0], sreg_bit[2:0]};
	endfunction

	task automatic emit(input word_t w);
		program_words[prog_len[6:0]] = w;
		prog_len = prog_len + 16'd1;
	endtask

	task automatic add_expected(input string name, input int port, input byte_t data);
		exp_names.push_back(name);
		exp_addrs.push_back(`AVR_IO_BASE + {10'b0, port[5:0]});
		exp_data.push_back(data);
	endtask

	task automatic stop_on_failure();
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("Fail %s: expected 0x%h, actual 0x%h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	// Returns on the negedge that sees the strobe
	task automatic wait_for_write(input string name);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!data_wen) begin
			if (cycles >= write_timeout) begin
				$display("Timeout: no I/O write for %s within %0d cycles", name, write_timeout);
				stop_on_failure();
			end
			cycles++;
			@(negedge clk);
		end
	endtask

	task automatic load_program();
		// Reset state, r5 never written
		emit(out_port('h01, 5));
		// LDI then OUT
		emit(reg_imm(op_ldi, 16, 8'h5A));
		emit(out_port('h02, 16));
		// SUBI without borrow
		emit(reg_imm(op_ldi, 17, 8'h10));
		emit(reg_imm(op_subi, 17, 8'h03));
		emit(out_port('h03, 17));
		// 16-bit subtract 0x0120 - 0x0030, borrow into SBCI
		emit(reg_imm(op_ldi, 18, 8'h20));
		emit(reg_imm(op_ldi, 19, 8'h01));
		emit(reg_imm(op_subi, 18, 8'h30));
		emit(reg_imm(op_sbci, 19, 8'h00));
		emit(out_port('h04, 18));
		emit(out_port('h05, 19));
		// ANDI and ORI
		emit(reg_imm(op_ldi, 20, 8'hC3));
		emit(reg_imm(op_andi, 20, 8'h5F));
		emit(out_port('h06, 20));
		emit(reg_imm(op_ori, 20, 8'h28));
		emit(out_port('h07, 20));
		// 0x12F0 + 0x0325 with ADD then ADC
		emit(reg_imm(op_ldi, 21, 8'hF0));
		emit(reg_imm(op_ldi, 22, 8'h25));
		emit(reg_imm(op_ldi, 23, 8'h12));
		emit(reg_imm(op_ldi, 24, 8'h03));
		emit(two_reg(op_add, 21, 22));
		emit(two_reg(op_adc, 23, 24));
		emit(out_port('h08, 21));
		emit(out_port('h09, 23));
		// LSL as ADD of a register with itself
		emit(reg_imm(op_ldi, 25, 8'h61));
		emit(two_reg(op_add, 25, 25));
		emit(out_port('h0A, 25));
		// Logic on copies in the low registers
		emit(reg_imm(op_ldi, 16, 8'hCC));
		emit(reg_imm(op_ldi, 17, 8'hAA));
		emit(two_reg(op_mov, 2, 16));
		emit(two_reg(op_mov, 3, 17));
		emit(two_reg(op_mov, 4, 16));
		emit(two_reg(op_mov, 6, 16));
		emit(two_reg(op_and, 2, 3));
		emit(two_reg(op_or, 4, 3));
		emit(two_reg(op_eor, 6, 3));
		emit(two_reg(op_mov, 7, 17));
		emit(out_port('h0B, 2));
		emit(out_port('h0C, 4));
		emit(out_port('h0D, 6));
		emit(out_port('h0E, 7));
		// Equal CP, Z set and C clear
		emit(reg_imm(op_ldi, 16, 8'h33));
		emit(reg_imm(op_ldi, 17, 8'h33));
		emit(two_reg(op_cp, 16, 17));
		emit(cond_branch(1'b1, `AVR_SREG_Z, 1));
		emit(out_port('h10, 16));
		emit(out_port('h11, 16));
		emit(cond_branch(1'b0, `AVR_SREG_C, 1));
		emit(out_port('h12, 16));
		emit(cond_branch(1'b0, `AVR_SREG_Z, 1));
		emit(out_port('h13, 17));
		// CPI below, C set and Z clear
		emit(reg_imm(op_ldi, 18, 8'h10));
		emit(reg_imm(op_cpi, 18, 8'h20));
		emit(cond_branch(1'b1, `AVR_SREG_C, 1));
		emit(out_port('h14, 18));
		emit(cond_branch(1'b1, `AVR_SREG_Z, 1));
		emit(out_port('h15, 18));
		// 16-bit compare, low bytes differ so chained Z stays clear
		emit(reg_imm(op_ldi, 20, 8'h05));
		emit(reg_imm(op_ldi, 21, 8'h77));
		emit(reg_imm(op_ldi, 22, 8'h04));
		emit(reg_imm(op_ldi, 23, 8'h77));
		emit(two_reg(op_cp, 20, 22));
		emit(two_reg(op_cpc, 21, 23));
		emit(cond_branch(1'b1, `AVR_SREG_Z, 1));
		emit(out_port('h16, 21));
		// Both bytes equal now
		emit(reg_imm(op_ldi, 22, 8'h05));
		emit(two_reg(op_cp, 20, 22));
		emit(two_reg(op_cpc, 21, 23));
		emit(cond_branch(1'b0, `AVR_SREG_Z, 1));
		emit(out_port('h17, 20));
		emit(cond_branch(1'b1, `AVR_SREG_Z, 1));
		emit(out_port('h18, 20));
		// RJMP over one OUT
		emit(reg_imm(op_ldi, 24, 8'h99));
		emit(rel_jump(1));
		emit(out_port('h19, 24));
		emit(out_port('h1A, 24));
		// Count down from 3, loop back while Z clear
		emit(reg_imm(op_ldi, 25, 8'h03));
		emit(out_port('h1B, 25));
		emit(reg_imm(op_subi, 25, 8'h01));
		emit(cond_branch(1'b0, `AVR_SREG_Z, -3));
		emit(out_port('h1C, 25));
		// Park on a jump to itself
		emit(rel_jump(-1));
		emit(out_port('h1F, 25));
	endtask

	// Only the OUTs that must reach the bus
	task automatic load_expected();
		add_expected("reset_zero", 'h01, 8'h00);
		add_expected("ldi", 'h02, 8'h5A);
		add_expected("subi", 'h03, 8'h0D);
		add_expected("subi_borrow", 'h04, 8'hF0);
		add_expected("sbci_carry", 'h05, 8'h00);
		add_expected("andi", 'h06, 8'h43);
		add_expected("ori", 'h07, 8'h6B);
		add_expected("add_low", 'h08, 8'h15);
		add_expected("adc_high", 'h09, 8'h16);
		add_expected("lsl", 'h0A, 8'hC2);
		add_expected("and", 'h0B, 8'h88);
		add_expected("or", 'h0C, 8'hEE);
		add_expected("eor", 'h0D, 8'h66);
		add_expected("mov", 'h0E, 8'hAA);
		add_expected("brbs_z_taken", 'h11, 8'h33);
		add_expected("brbc_z_not_taken", 'h13, 8'h33);
		add_expected("cpi_brbs_z_not_taken", 'h15, 8'h10);
		add_expected("cpc_chained_z", 'h16, 8'h77);
		add_expected("cpc_equal", 'h17, 8'h05);
		add_expected("rjmp_target", 'h1A, 8'h99);
		add_expected("loop_pass_1", 'h1B, 8'h03);
		add_expected("loop_pass_2", 'h1B, 8'h02);
		add_expected("loop_pass_3", 'h1B, 8'h01);
		add_expected("loop_exit", 'h1C, 8'h00);
	endtask

	initial begin
		reset = 1'b1;
		prog_len = 16'd0;
		load_program();
		load_expected();

		// Three clock edges in reset
		repeat (3) begin
			@(negedge clk);
			check_value("reset pc", `AVR_RESET_PC, pc);
			check_value("reset data_wen", 16'h0000, {15'b0, data_wen});
		end
		reset = 1'b0;
		@(negedge clk);
		check_value("first cycle data_wen", 16'h0000, {15'b0, data_wen});

		for (int i = 0; i < exp_names.size(); i++) begin
			wait_for_write(exp_names[i]);
			check_value({exp_names[i], " address"}, exp_addrs[i], data_addr);
			check_value({exp_names[i], " data"}, {8'h00, exp_data[i]}, {8'h00, data_write});
		end

		// Core is parked, the bus must stay idle
		for (int c = 0; c < quiet_cycles; c++) begin
			@(negedge clk);
			if (data_wen) begin
				$display("Unexpected extra write to 0x%h after the last expected write", data_addr);
				stop_on_failure();
			end
		end

		$display("TEST OK");
		$finish;
	end

endmodule

// File: sources.f
+incdir+logic
logic/avr_pkg.sv
logic/fetch_stage.sv
logic/instr_decoder.sv
logic/alu.sv
logic/register_file.sv
logic/execute_stage.sv
logic/avr_core.sv
verification/avr_core_tb.sv

// File: run_sim.sh
#!/bin/bash

rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f sources.f \
	--top-module avr_core_tb -Mdir obj_dir -o avr_core_sim \
	&& { ./obj_dir/avr_core_sim > sim.log 2>&1 || true; } \
	&& cat sim.log \
	&& ! grep -q "TEST FAILED" sim.log \
	&& grep -q "TEST OK" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
